// ==== eth_loop_defs.svh ====
// Loopback core sizing: channel count, beat widths, frame limits, FIFO depth, counter width
`ifndef ETH_LOOP_DEFS_SVH
`define ETH_LOOP_DEFS_SVH

// Number of loopback channels
`define ETH_CH_CNT 4

// Beat payload and byte enables
`define ETH_DATA_W 64
`define ETH_KEEP_W 8

// Legal frame length in beats (64 bytes minimum)
`define ETH_MIN_FRAME_BEATS 8
`define ETH_MAX_FRAME_BEATS 32

// Beats of storage per channel
`define ETH_FIFO_DEPTH 64

// Statistics counter width
`define STAT_COUNT_W 32

`endif

// ==== eth_loop_pkg.sv ====
// Shared loopback types: frame beat, statistics outcome kind and statistics id
`include "eth_loop_defs.svh"

package eth_loop_pkg;

    // Channel field width inside a statistics id
    localparam int CH_W = $clog2(`ETH_CH_CNT);

    // One receive or transmit beat, user marks the frame as bad
    typedef struct packed {
        logic [`ETH_DATA_W-1:0] data;
        logic [`ETH_KEEP_W-1:0] keep;
        logic                   last;
        logic                   user;
    } eth_beat_t;

    // Per-frame outcome
    typedef enum logic [1:0] {
        STAT_GOOD = 2'd0,
        STAT_BAD  = 2'd1,
        STAT_DROP = 2'd2
    } stat_kind_e;

    typedef struct packed {
        logic [CH_W-1:0] ch;
        stat_kind_e      kind;
    } stat_field_t;

    // Counter id, flat index or channel plus kind
    typedef union packed {
        logic [CH_W+1:0] idx;
        stat_field_t     f;
    } stat_id_u;

endpackage

// ==== rx_frame_check.sv ====
// Receive frame checker: registers MAC beats and flags runt, oversize and errored frames
`timescale 1ns/1ps
`include "eth_loop_defs.svh"

module rx_frame_check (
    input  logic                    clk_125mhz,
    input  logic                    rst_n_i,
    input  logic                    rx_valid_i,
    input  eth_loop_pkg::eth_beat_t rx_beat_i,
    output logic                    chk_valid_o,
    output eth_loop_pkg::eth_beat_t chk_beat_o,
    output logic                    chk_bad_o
);

    // Count saturates one past the maximum so oversize stays visible
    localparam int CNT_W = $clog2(`ETH_MAX_FRAME_BEATS + 2);
    localparam logic [CNT_W-1:0] LEN_MIN = CNT_W'(`ETH_MIN_FRAME_BEATS);
    localparam logic [CNT_W-1:0] LEN_MAX = CNT_W'(`ETH_MAX_FRAME_BEATS);
    localparam logic [CNT_W-1:0] LEN_SAT = CNT_W'(`ETH_MAX_FRAME_BEATS + 1);

    // Beats already seen in the current frame
    logic [CNT_W-1:0] beat_cnt;
    // Length including the current beat
    logic [CNT_W-1:0] beat_len;
    logic             err_seen;
    logic             frame_bad;

    assign beat_len = beat_cnt + 1'b1;

    // Only meaningful on the last beat
    assign frame_bad = err_seen || rx_beat_i.user ||
                       (beat_len < LEN_MIN) || (beat_len > LEN_MAX);

    always_ff @(posedge clk_125mhz or negedge rst_n_i) begin
        if (!rst_n_i) begin
            beat_cnt    <= '0;
            err_seen    <= 1'b0;
            chk_valid_o <= 1'b0;
            chk_bad_o   <= 1'b0;
        end else begin
            chk_valid_o <= rx_valid_i;
            chk_bad_o   <= rx_valid_i && rx_beat_i.last && frame_bad;
            if (rx_valid_i) begin
                if (rx_beat_i.last) begin
                    beat_cnt <= '0;
                    err_seen <= 1'b0;
                end else begin
                    beat_cnt <= (beat_len > LEN_SAT) ? LEN_SAT : beat_len;
                    err_seen <= err_seen || rx_beat_i.user;
                end
            end
        end
    end

    // Beat payload
    always_ff @(posedge clk_125mhz) begin
        chk_beat_o <= rx_beat_i;
    end

endmodule

// ==== frame_fifo.sv ====
// Store-and-forward frame FIFO with commit, rollback and per-frame outcome events
`timescale 1ns/1ps
`include "eth_loop_defs.svh"

module frame_fifo #(
    parameter int CH = 0
) (
    input  logic                    clk_125mhz,
    input  logic                    rst_n_i,
    input  logic                    chk_valid_i,
    input  eth_loop_pkg::eth_beat_t chk_beat_i,
    input  logic                    chk_bad_i,
    output logic                    tx_valid_o,
    output eth_loop_pkg::eth_beat_t tx_beat_o,
    input  logic                    tx_ready_i,
    output logic                    evt_valid_o,
    output eth_loop_pkg::stat_id_u  evt_id_o
);

    import eth_loop_pkg::*;

    localparam int ADDR_W = $clog2(`ETH_FIFO_DEPTH);
    localparam int PTR_W  = ADDR_W + 1;

    eth_beat_t mem [`ETH_FIFO_DEPTH];

    // Extra MSB on each pointer tells full from empty
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] wr_commit;
    logic [PTR_W-1:0] rd_ptr;

    logic [PTR_W-1:0] used;
    logic [PTR_W:0]   level;
    logic             full;
    logic             drop_seen;
    logic             wr_en;
    logic             frame_drop;
    logic             rd_load;

    // Occupancy counts the beat held in the output register too
    assign used  = wr_ptr - rd_ptr;
    assign level = {1'b0, used} + (PTR_W+1)'(tx_valid_o);
    assign full  = level >= (PTR_W+1)'(`ETH_FIFO_DEPTH);

    // Once a beat hits a full FIFO the rest of the frame is discarded
    assign wr_en      = chk_valid_i && !full && !drop_seen;
    assign frame_drop = drop_seen || full;

    assign rd_load = (rd_ptr != wr_commit) && (!tx_valid_o || tx_ready_i);

    always_ff @(posedge clk_125mhz) begin
        if (wr_en) begin
            mem[wr_ptr[ADDR_W-1:0]] <= chk_beat_i;
        end
    end

    // Write side, commit or rollback on the last beat
    always_ff @(posedge clk_125mhz or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr      <= '0;
            wr_commit   <= '0;
            drop_seen   <= 1'b0;
            evt_valid_o <= 1'b0;
        end else begin
            evt_valid_o <= chk_valid_i && chk_beat_i.last;
            if (chk_valid_i && chk_beat_i.last) begin
                drop_seen <= 1'b0;
                if (chk_bad_i || frame_drop) begin
                    wr_ptr <= wr_commit;
                end else begin
                    wr_ptr    <= wr_ptr + 1'b1;
                    wr_commit <= wr_ptr + 1'b1;
                end
            end else if (chk_valid_i) begin
                drop_seen <= frame_drop;
                if (wr_en) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
        end
    end

    // Event id, bad takes precedence over drop
    always_ff @(posedge clk_125mhz) begin
        if (chk_valid_i && chk_beat_i.last) begin
            evt_id_o.f.ch <= CH_W'(CH);
            if (chk_bad_i) begin
                evt_id_o.f.kind <= STAT_BAD;
            end else if (frame_drop) begin
                evt_id_o.f.kind <= STAT_DROP;
            end else begin
                evt_id_o.f.kind <= STAT_GOOD;
            end
        end
    end

    // Registered output stage, holds under back-pressure
    always_ff @(posedge clk_125mhz or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_ptr     <= '0;
            tx_valid_o <= 1'b0;
        end else if (rd_load) begin
            rd_ptr     <= rd_ptr + 1'b1;
            tx_valid_o <= 1'b1;
        end else if (tx_ready_i) begin
            tx_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (rd_load) begin
            tx_beat_o <= mem[rd_ptr[ADDR_W-1:0]];
        end
    end

endmodule

// ==== stat_arb_mux.sv ====
// Round-robin collector of per-channel outcome events into one increment stream
`timescale 1ns/1ps
`include "eth_loop_defs.svh"

module stat_arb_mux (
    input  logic                   clk_125mhz,
    input  logic                   rst_n_i,
    input  logic                   evt_valid_i [`ETH_CH_CNT],
    input  eth_loop_pkg::stat_id_u evt_id_i [`ETH_CH_CNT],
    output logic                   inc_valid_o,
    output eth_loop_pkg::stat_id_u inc_id_o
);

    import eth_loop_pkg::*;

    logic            pend     [`ETH_CH_CNT];
    stat_id_u        pend_id  [`ETH_CH_CNT];
    logic            req      [`ETH_CH_CNT];
    stat_id_u        req_id   [`ETH_CH_CNT];
    logic [CH_W-1:0] last_gnt;
    logic [CH_W-1:0] gnt_idx;
    logic            gnt_found;

    // New events compete in the same cycle they arrive
    always_comb begin
        for (int i = 0; i < `ETH_CH_CNT; i++) begin
            req[i]    = pend[i] || evt_valid_i[i];
            req_id[i] = pend[i] ? pend_id[i] : evt_id_i[i];
        end
    end

    // First requester after the last grant
    always_comb begin
        logic [CH_W-1:0] cand;
        gnt_found = 1'b0;
        gnt_idx   = '0;
        cand      = '0;
        for (int i = 1; i <= `ETH_CH_CNT; i++) begin
            cand = CH_W'((int'(last_gnt) + i) % `ETH_CH_CNT);
            if (!gnt_found && req[cand]) begin
                gnt_found = 1'b1;
                gnt_idx   = cand;
            end
        end
    end

    always_ff @(posedge clk_125mhz or negedge rst_n_i) begin
        if (!rst_n_i) begin
            last_gnt    <= CH_W'(`ETH_CH_CNT - 1);
            inc_valid_o <= 1'b0;
            for (int i = 0; i < `ETH_CH_CNT; i++) begin
                pend[i] <= 1'b0;
            end
        end else begin
            inc_valid_o <= gnt_found;
            if (gnt_found) begin
                last_gnt <= gnt_idx;
            end
            for (int i = 0; i < `ETH_CH_CNT; i++) begin
                pend[i] <= req[i] && !(gnt_found && gnt_idx == CH_W'(i));
            end
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (gnt_found) begin
            inc_id_o <= req_id[gnt_idx];
        end
        for (int i = 0; i < `ETH_CH_CNT; i++) begin
            if (evt_valid_i[i] && !pend[i]) begin
                pend_id[i] <= evt_id_i[i];
            end
        end
    end

endmodule

// ==== stat_counters.sv ====
// Statistics counter bank, incremented by id and read through a registered port
`timescale 1ns/1ps
`include "eth_loop_defs.svh"

module stat_counters (
    input  logic                      clk_125mhz,
    input  logic                      rst_n_i,
    input  logic                      inc_valid_i,
    input  eth_loop_pkg::stat_id_u    inc_id_i,
    input  eth_loop_pkg::stat_id_u    stat_rd_addr_i,
    output logic [`STAT_COUNT_W-1:0]  stat_rd_data_o
);

    import eth_loop_pkg::*;

    // One counter per flat id position
    localparam int CNT_NUM = 2 ** $bits(stat_id_u);

    logic [`STAT_COUNT_W-1:0] cnt [CNT_NUM];

    // Increment on the flat view of the id
    always_ff @(posedge clk_125mhz or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < CNT_NUM; i++) begin
                cnt[i] <= '0;
            end
        end else if (inc_valid_i) begin
            cnt[inc_id_i.idx] <= cnt[inc_id_i.idx] + 1'b1;
        end
    end

    // Registered read
    always_ff @(posedge clk_125mhz or negedge rst_n_i) begin
        if (!rst_n_i) begin
            stat_rd_data_o <= '0;
        end else begin
            stat_rd_data_o <= cnt[stat_rd_addr_i.idx];
        end
    end

endmodule

// ==== eth_loop_core.sv ====
// Multi-channel Ethernet loopback top: frame checkers, frame FIFOs and statistics
`timescale 1ns/1ps
`include "eth_loop_defs.svh"

module eth_loop_core (
    input  logic                      clk_125mhz,
    input  logic                      rst_n_i,
    input  logic                      rx_valid_i [`ETH_CH_CNT],
    input  eth_loop_pkg::eth_beat_t   rx_beat_i [`ETH_CH_CNT],
    output logic                      tx_valid_o [`ETH_CH_CNT],
    output eth_loop_pkg::eth_beat_t   tx_beat_o [`ETH_CH_CNT],
    input  logic                      tx_ready_i [`ETH_CH_CNT],
    input  eth_loop_pkg::stat_id_u    stat_rd_addr_i,
    output logic [`STAT_COUNT_W-1:0]  stat_rd_data_o
);

    import eth_loop_pkg::*;

    logic      chk_valid [`ETH_CH_CNT];
    eth_beat_t chk_beat  [`ETH_CH_CNT];
    logic      chk_bad   [`ETH_CH_CNT];
    logic      evt_valid [`ETH_CH_CNT];
    stat_id_u  evt_id    [`ETH_CH_CNT];
    logic      inc_valid;
    stat_id_u  inc_id;

    for (genvar n = 0; n < `ETH_CH_CNT; n++) begin : g_ch

        rx_frame_check rx_frame_check_inst (
            .clk_125mhz  (clk_125mhz),
            .rst_n_i     (rst_n_i),
            .rx_valid_i  (rx_valid_i[n]),
            .rx_beat_i   (rx_beat_i[n]),
            .chk_valid_o (chk_valid[n]),
            .chk_beat_o  (chk_beat[n]),
            .chk_bad_o   (chk_bad[n])
        );

        frame_fifo #(
            .CH (n)
        ) frame_fifo_inst (
            .clk_125mhz  (clk_125mhz),
            .rst_n_i     (rst_n_i),
            .chk_valid_i (chk_valid[n]),
            .chk_beat_i  (chk_beat[n]),
            .chk_bad_i   (chk_bad[n]),
            .tx_valid_o  (tx_valid_o[n]),
            .tx_beat_o   (tx_beat_o[n]),
            .tx_ready_i  (tx_ready_i[n]),
            .evt_valid_o (evt_valid[n]),
            .evt_id_o    (evt_id[n])
        );

    end

    // Outcome events from all channels into one increment stream
    stat_arb_mux stat_arb_mux_inst (
        .clk_125mhz  (clk_125mhz),
        .rst_n_i     (rst_n_i),
        .evt_valid_i (evt_valid),
        .evt_id_i    (evt_id),
        .inc_valid_o (inc_valid),
        .inc_id_o    (inc_id)
    );

    stat_counters stat_counters_inst (
        .clk_125mhz     (clk_125mhz),
        .rst_n_i        (rst_n_i),
        .inc_valid_i    (inc_valid),
        .inc_id_i       (inc_id),
        .stat_rd_addr_i (stat_rd_addr_i),
        .stat_rd_data_o (stat_rd_data_o)
    );

endmodule

// ==== tb_eth_loop_core.sv ====
// Directed testbench for the loopback core with frame driver, tx scoreboard and counter checks
`timescale 1ns/1ps
`include "eth_loop_defs.svh"

module tb_eth_loop_core;

    import eth_loop_pkg::*;

    localparam int NCH     = `ETH_CH_CNT;
    localparam int ID_W    = $bits(stat_id_u);
    localparam int KINDS   = 4;
    localparam int TIMEOUT = 3000;

    logic                     clk_125mhz;
    logic                     rst_n;
    logic                     rx_valid [NCH];
    eth_beat_t                rx_beat  [NCH];
    logic                     tx_valid [NCH];
    eth_beat_t                tx_beat  [NCH];
    logic                     tx_ready [NCH];
    stat_id_u                 rd_addr;
    logic [`STAT_COUNT_W-1:0] rd_data;

    // Ready source per channel (0 low, 1 high, 2 random)
    int        ready_mode [NCH];
    eth_beat_t exp_q [NCH][$];
    int        exp_cnt [2**ID_W];
    logic      held_v [NCH];
    eth_beat_t held_b [NCH];
    int        seed;

    eth_loop_core eth_loop_core_inst (
        .clk_125mhz     (clk_125mhz),
        .rst_n_i        (rst_n),
        .rx_valid_i     (rx_valid),
        .rx_beat_i      (rx_beat),
        .tx_valid_o     (tx_valid),
        .tx_beat_o      (tx_beat),
        .tx_ready_i     (tx_ready),
        .stat_rd_addr_i (rd_addr),
        .stat_rd_data_o (rd_data)
    );

    initial begin
        clk_125mhz = 1'b0;
        forever #2 clk_125mhz = ~clk_125mhz;
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping at first error");
    endtask

    // Transmit ready pattern
    initial begin
        for (int c = 0; c < NCH; c++) begin
            tx_ready[c] = 1'b1;
        end
        forever begin
            @(negedge clk_125mhz);
            for (int c = 0; c < NCH; c++) begin
                tx_ready[c] = (ready_mode[c] == 2) ? 1'($random(seed)) : (ready_mode[c] == 1);
            end
        end
    end

    // Transmit monitor and scoreboard
    always @(posedge clk_125mhz) begin
        eth_beat_t exp_b;
        for (int c = 0; c < NCH; c++) begin
            if (!rst_n) begin
                held_v[c] = 1'b0;
            end else begin
                if (held_v[c]) begin
                    assert (tx_valid[c] && tx_beat[c] === held_b[c]) else
                        abort_run($sformatf("ERR %0t: ch %0d beat changed while stalled",
                                            $time, c));
                end
                held_v[c] = tx_valid[c] && !tx_ready[c];
                held_b[c] = tx_beat[c];
                if (tx_valid[c] && tx_ready[c]) begin
                    assert (exp_q[c].size() > 0) else
                        abort_run($sformatf("ERR %0t: ch %0d unexpected beat %h",
                                            $time, c, tx_beat[c]));
                    exp_b = exp_q[c].pop_front();
                    assert (tx_beat[c] === exp_b) else
                        abort_run($sformatf("ERR %0t: ch %0d beat %h, expected %h",
                                            $time, c, tx_beat[c], exp_b));
                end
            end
        end
    end

    // Drives one frame with user set on beat bad_at
    task automatic send_frame(input int ch, input int len, input int bad_at);
        eth_beat_t b;
        eth_beat_t frame [$];
        logic      bad;
        bad = (len < `ETH_MIN_FRAME_BEATS) || (len > `ETH_MAX_FRAME_BEATS) || (bad_at >= 0);
        for (int i = 0; i < len; i++) begin
            b.data = {$random(seed), $random(seed)};
            b.keep = (i == len - 1) ? `ETH_KEEP_W'($random(seed)) : '1;
            b.last = (i == len - 1);
            b.user = (i == bad_at);
            frame.push_back(b);
        end
        // Bad wins over drop and a frame that does not fit is dropped whole
        if (bad) begin
            exp_cnt[ch * KINDS + int'(STAT_BAD)]++;
        end else if (exp_q[ch].size() + len > `ETH_FIFO_DEPTH) begin
            exp_cnt[ch * KINDS + int'(STAT_DROP)]++;
        end else begin
            exp_cnt[ch * KINDS + int'(STAT_GOOD)]++;
            foreach (frame[i]) begin
                exp_q[ch].push_back(frame[i]);
            end
        end
        foreach (frame[i]) begin
            @(negedge clk_125mhz);
            rx_valid[ch] = 1'b1;
            rx_beat[ch]  = frame[i];
        end
        @(negedge clk_125mhz);
        rx_valid[ch] = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        int pend;
        n = 0;
        do begin
            @(negedge clk_125mhz);
            pend = 0;
            for (int c = 0; c < NCH; c++) begin
                pend += exp_q[c].size();
            end
            n++;
            if (n > TIMEOUT) begin
                abort_run("Timeout while waiting for transmit frames");
            end
        end while (pend != 0);
    endtask

    task automatic check_counters();
        int n;
        for (int i = 0; i < 2**ID_W; i++) begin
            @(negedge clk_125mhz);
            rd_addr.idx = ID_W'(i);
            @(negedge clk_125mhz);
            n = 0;
            while (rd_data != `STAT_COUNT_W'(exp_cnt[i]) && n < TIMEOUT) begin
                @(negedge clk_125mhz);
                n++;
            end
            assert (rd_data == `STAT_COUNT_W'(exp_cnt[i])) else
                abort_run($sformatf("ERR %0t: counter %0d reads %0d, expected %0d",
                                    $time, i, rd_data, exp_cnt[i]));
        end
    endtask

    task automatic check_reset_state();
        for (int c = 0; c < NCH; c++) begin
            assert (tx_valid[c] === 1'b0) else
                abort_run($sformatf("ERR %0t: ch %0d tx valid set after reset", $time, c));
        end
        check_counters();
    endtask

    task automatic send_good_frames();
        send_frame(0, `ETH_MIN_FRAME_BEATS, -1);
        repeat (4) send_frame(0, 8 + (($random(seed) & 32'h7fffffff) % 25), -1);
        send_frame(0, `ETH_MAX_FRAME_BEATS, -1);
        wait_drain();
        check_counters();
    endtask

    task automatic send_bad_frames();
        send_frame(0, 10, -1);
        send_frame(0, `ETH_MIN_FRAME_BEATS - 1, -1);
        send_frame(0, 10, -1);
        send_frame(0, `ETH_MAX_FRAME_BEATS + 1, -1);
        send_frame(0, 10, -1);
        send_frame(0, 12, 6);
        send_frame(0, 10, -1);
        wait_drain();
        check_counters();
    endtask

    task automatic stall_transmit();
        ready_mode[2] = 2;
        send_frame(2, 8, -1);
        send_frame(2, 20, -1);
        send_frame(2, 30, -1);
        wait_drain();
        ready_mode[2] = 1;
        check_counters();
    endtask

    // Three frames fill 60 beats and the last two do not fit
    task automatic overflow_fifo();
        ready_mode[1] = 0;
        @(negedge clk_125mhz);
        repeat (4) send_frame(1, 20, -1);
        send_frame(1, 8, -1);
        check_counters();
        ready_mode[1] = 1;
        wait_drain();
        check_counters();
    endtask

    task automatic channel_traffic(input int ch);
        send_frame(ch, 8 + ch * 4, -1);
        send_frame(ch, 7, -1);
        send_frame(ch, 16, 3 + ch);
        send_frame(ch, 24, -1);
    endtask

    task automatic drive_all_channels();
        fork
            channel_traffic(0);
            channel_traffic(1);
            channel_traffic(2);
            channel_traffic(3);
        join
        wait_drain();
        check_counters();
    endtask

    initial begin
        seed    = 32'h69dd74f3;
        rst_n   = 1'b0;
        rd_addr = '0;
        for (int c = 0; c < NCH; c++) begin
            rx_valid[c]   = 1'b0;
            rx_beat[c]    = '0;
            ready_mode[c] = 1;
        end
        foreach (exp_cnt[i]) begin
            exp_cnt[i] = 0;
        end
        repeat (2) @(posedge clk_125mhz);
        @(negedge clk_125mhz);
        rst_n = 1'b1;
        check_reset_state();
        send_good_frames();
        send_bad_frames();
        stall_transmit();
        overflow_fifo();
        drive_all_channels();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+.
eth_loop_pkg.sv
rx_frame_check.sv
frame_fifo.sv
stat_arb_mux.sv
stat_counters.sv
eth_loop_core.sv
tb_eth_loop_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the loopback testbench, the log decides pass or fail
rm -f sim.log
verilator --binary --timing --assert -f list.f --top-module tb_eth_loop_core -o tb_sim \
    && ./obj_dir/tb_sim | tee sim.log
grep -q "^\*\*\* TEST PASSED \*\*\*$" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
